// ==== Makefile ====
# Verilator flow for the random word generator testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rng
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

# the run passes only if the pass line appears in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/rng_macros.svh ====
// random word generator constants
// widths, seeds, reset stretch length and the recommended read spacing
// shared by every block of the generator

`ifndef RNG_MACROS_SVH
`define RNG_MACROS_SVH

// width of one random word and of each LFSR output half
`define RNG_WORD_W 32

// width of the full LFSR state
`define RNG_LFSR_W 64

// start state of the LFSR clocked by clk1
`define RNG_SEED_FAST 64'hAAAA_AAAA_AAAA_AAAA

// start state of the LFSR clocked by clk2
// it differs from the fast seed so the two sequences never line up
`define RNG_SEED_SLOW 64'hBBBB_BBBB_BBBB_BBBB

// number of clk2 rising edges that must be seen after rst falls
// before the slow LFSR leaves its reset
`define RNG_RESET_STRETCH 3

// clk1 cycles without a read after which a new word counts as fresh
// reading faster than this returns words that are strongly correlated
`define RNG_REFRESH_CYCLES 32

`endif

// ==== common/rng_pkg.sv ====
// random word generator types
// the word type carried between the sources, the mixer and the consumer,
// and the state type of the LFSRs and their seeds

`include "rng_macros.svh"

package rng_pkg;

	// one random word
	// this is also the low half of an LFSR state that each source exposes
	typedef logic [`RNG_WORD_W-1:0] rng_word_t;

	// full LFSR state
	// the seed parameter of each LFSR has this type as well
	typedef logic [`RNG_LFSR_W-1:0] lfsr_state_t;

	// the generator is made of two such LFSRs
	// one runs on clk1 and the other on the unrelated clk2,
	// and only their low halves are mixed into the output word

	// a state of all ones locks an xnor LFSR in place,
	// so any seed given to lfsr64 must avoid that value

	// the upper half of each state never leaves its LFSR
	// it only feeds the taps of the feedback

	// the word type is shared between clock domains as well:
	// slow_source carries a word of this type from clk2 into clk1

endpackage

// ==== design/lfsr64.sv ====
// 64-bit fibonacci LFSR
// an xnor of taps 63, 62, 60 and 59 shifts in at bit 0 on every clock
// and the low half of the state is presented as the output word

`timescale 1ns/1ps

`include "rng_macros.svh"

module lfsr64 #(
	// state loaded while rst is high
	parameter rng_pkg::lfsr_state_t seed = '0
) (
	input  logic               clk,
	input  logic               rst,
	output rng_pkg::rng_word_t word
);

	// current shift register contents
	rng_pkg::lfsr_state_t state;

	// bit that enters at the bottom on the next shift
	logic feedback;

	// taps 64, 63, 61 and 60 in the usual one-based notation
	// give a maximal length sequence for a 64-bit register
	// the xnor form makes the all-zero state legal and all ones the
	// single lockup state instead
	assign feedback = ~(state[63] ^ state[62] ^ state[60] ^ state[59]);

	// rst holds the register on its seed
	// once released it shifts left by one position every clock
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seed;
		end else begin
			state <= {state[`RNG_LFSR_W-2:0], feedback};
		end
	end

	// only the low half leaves the block
	// the upper bits stay hidden and keep the output hard to predict
	// from a single word
	assign word = state[`RNG_WORD_W-1:0];

	// with rst low for k clock edges the state has shifted k times
	// a model can therefore step its own copy once per edge after
	// the release and compare against the output word

	// the register has no enable and runs freely
	// a caller that needs a gated sequence must gate the clock itself

endmodule

// ==== design/rng_mixer.sv ====
// output mixer
// XORs the fast and slow words every clk1 cycle, latches the mixed word
// on a read strobe and reports when enough cycles have passed since the
// last read for the next word to be fresh

`timescale 1ns/1ps

`include "rng_macros.svh"

module rng_mixer (
	input  logic               clk1,
	input  logic               rst,
	input  rng_pkg::rng_word_t fast_word,
	input  rng_pkg::rng_word_t slow_word,
	input  logic               rd,
	output rng_pkg::rng_word_t rng_word,
	output logic               fresh
);

	// width that holds the spacing count up to its saturation value
	localparam int gap_w = $clog2(`RNG_REFRESH_CYCLES + 1);

	// count at which the next word is considered fresh
	localparam logic [gap_w-1:0] gap_max = gap_w'(`RNG_REFRESH_CYCLES);

	// mixed word, one cycle behind the two sources
	rng_pkg::rng_word_t mix;

	// clk1 cycles since the last read or since reset
	logic [gap_w-1:0] gap_cnt;

	// both sources combine with a plain XOR
	// the fast LFSR keeps the word changing every cycle while the slow
	// one adds a sequence whose phase depends on the unrelated clk2,
	// so each power up gives a different stream
	always_ff @(posedge clk1) begin
		mix <= fast_word ^ slow_word;
	end

	// a read at edge n returns what mix held just before that edge
	// the word then holds until the next read
	// rst clears it so the consumer never sees a word from before reset
	always_ff @(posedge clk1) begin
		if (rst) begin
			rng_word <= '0;
		end else if (rd) begin
			rng_word <= mix;
		end
	end

	// the spacing count restarts on every read and on rst
	// otherwise it climbs by one per cycle and sticks at its maximum
	always_ff @(posedge clk1) begin
		if (rst || rd) begin
			gap_cnt <= '0;
		end else if (gap_cnt != gap_max) begin
			gap_cnt <= gap_cnt + 1'b1;
		end
	end

	// fresh is high once the count has saturated
	// it drops on the same edge that samples rd,
	// since that edge also clears the count
	assign fresh = (gap_cnt == gap_max);

	// after rst falls the count needs the full refresh period,
	// so fresh stays low for that many cycles as well

	// a read while fresh is low is still served
	// it only restarts the count and never stalls the consumer

	// with a constant slow word two reads differ only by the fast
	// LFSR steps between them, which is why the spacing matters
	// a consumer that reads on every cycle sees one shifted LFSR

	// the read strobe is sampled as a level on each edge
	// holding it high for several cycles returns a new word each cycle
	// and keeps fresh low for as long as it stays high

	// neither the word nor the flag depends on clk2 directly
	// the slow source is already in the clk1 domain when it arrives

endmodule

// ==== design/rng_top.sv ====
// random word generator top level
// a fast LFSR on clk1 and a slow source on the unrelated clk2 feed a
// mixer that hands out one word per read strobe with a freshness flag

`timescale 1ns/1ps

`include "rng_macros.svh"

module rng_top (
	input  logic               clk1,
	input  logic               clk2,
	input  logic               rst,
	input  logic               rd,
	output rng_pkg::rng_word_t rng_word,
	output logic               fresh
);

	// low half of the fast LFSR, in the clk1 domain
	rng_pkg::rng_word_t fast_word;

	// low half of the slow LFSR, already brought into clk1
	rng_pkg::rng_word_t slow_word;

	// fast source
	// rst is synchronous to clk1 and drives this LFSR directly
	lfsr64 #(
		.seed (`RNG_SEED_FAST)
	) i_fast_lfsr (
		.clk  (clk1),
		.rst  (rst),
		.word (fast_word)
	);

	// slow source
	// it handles the reset stretch into clk2 and the crossing back
	slow_source i_slow_source (
		.clk1      (clk1),
		.clk2      (clk2),
		.rst       (rst),
		.slow_word (slow_word)
	);

	// mixer and read side
	// everything here runs on clk1
	rng_mixer i_mixer (
		.clk1      (clk1),
		.rst       (rst),
		.fast_word (fast_word),
		.slow_word (slow_word),
		.rd        (rd),
		.rng_word  (rng_word),
		.fresh     (fresh)
	);

	// a read sampled at the n-th clk1 edge after the release returns
	// the fast low half after n-2 shifts XORed with the slow word,
	// as long as the slow word has been stable for three cycles

endmodule

// ==== slow_source/slow_source.sv ====
// slow entropy source
// stretches the clk1 reset across several clk2 edges, runs an LFSR on clk2
// and brings its low half back into the clk1 domain through two flops

`timescale 1ns/1ps

`include "rng_macros.svh"

module slow_source (
	input  logic               clk1,
	input  logic               clk2,
	input  logic               rst,
	output rng_pkg::rng_word_t slow_word
);

	// width needed to hold the stretch count down to zero
	localparam int stretch_w = $clog2(`RNG_RESET_STRETCH + 1);

	// value loaded into the stretch counter by rst
	localparam logic [stretch_w-1:0] stretch_load = stretch_w'(`RNG_RESET_STRETCH);

	// clk2 sampled on clk1
	// clk2_q0 is the newer sample and clk2_q1 the one before it
	logic clk2_q0;
	logic clk2_q1;

	// one clk1 cycle pulse when a clk2 rising edge has been seen
	logic clk2_rise;

	// clk2 rising edges still to be seen before the slow LFSR is released
	logic [stretch_w-1:0] stretch_cnt;

	// reset of the slow LFSR, registered in the clk2 domain
	logic slow_rst;

	// low half of the slow LFSR, still in the clk2 domain
	rng_pkg::rng_word_t slow_raw;

	// first stage of the crossing back into clk1
	rng_pkg::rng_word_t slow_sync;

	// clk2 is at most half as fast as clk1, so sampling it as data
	// on clk1 catches every high and every low phase at least once
	always_ff @(posedge clk1) begin
		clk2_q0 <= clk2;
		clk2_q1 <= clk2_q0;
	end

	// a low to high step between the two samples is a clk2 rising edge
	assign clk2_rise = clk2_q0 & ~clk2_q1;

	// rst loads the full stretch count
	// each clk2 edge seen afterwards takes one off until it reaches zero
	always_ff @(posedge clk1) begin
		if (rst) begin
			stretch_cnt <= stretch_load;
		end else if (clk2_rise && stretch_cnt != '0) begin
			stretch_cnt <= stretch_cnt - 1'b1;
		end
	end

	// the count is quasi static once rst has been seen, so clk2 can
	// register it directly
	// it stays non-zero for several clk2 edges after rst falls,
	// which gives the slow LFSR a reset it cannot miss
	always_ff @(posedge clk2) begin
		slow_rst <= (stretch_cnt != '0);
	end

	// second source, free running on the unrelated oscillator
	lfsr64 #(
		.seed (`RNG_SEED_SLOW)
	) i_slow_lfsr (
		.clk  (clk2),
		.rst  (slow_rst),
		.word (slow_raw)
	);

	// two clk1 flops carry the slow word into the clk1 domain
	// clk2 changes slow_raw at most once every two clk1 cycles,
	// so the second flop only ever presents a settled word
	always_ff @(posedge clk1) begin
		slow_sync <= slow_raw;
		slow_word <= slow_sync;
	end

	// slow_word trails the clk2 state by two to three clk1 cycles
	// the exact lag depends on where the clk2 edge falls within a
	// clk1 period and is not flagged to the mixer

	// while clk2 is stopped the slow LFSR holds its state,
	// so slow_word settles on a constant value after the crossing delay

	// the stretch counter runs from rst on every assertion,
	// so a reset in mid-run also returns the slow LFSR to its seed
	// once clk2 has produced enough edges to register it

endmodule

// ==== sources.f ====
+incdir+common
+incdir+tb
common/rng_pkg.sv
design/lfsr64.sv
slow_source/slow_source.sv
design/rng_mixer.sv
design/rng_top.sv
tb/tb_rng.sv

// ==== tb/tb_rng_table.svh ====
// stimulus table, LFSR reference model and compare tasks for tb_rng
// each row gives a gap before a read, the clk2 state during the gap
// and the fresh level expected just before the read

`ifndef TB_RNG_TABLE_SVH
`define TB_RNG_TABLE_SVH

// one row of stimulus and expectation
// rst_before applies a full reset ahead of the gap
// rand_gap replaces gap with a draw of 32 to 63 cycles
typedef struct packed {
	logic rst_before;
	int   gap;
	logic rand_gap;
	logic clk2_on;
	logic fresh_exp;
} row_t;

localparam int num_rows = 14;

// rows 1 to 5 and 10 to 13 stop clk2 so the slow word stays constant
// rows 6 to 8 let clk2 run so the slow word keeps moving
// row 9 resets the generator in mid-run
row_t table_rows [num_rows] = '{
	'{1'b1, 32, 1'b0, 1'b1, 1'b1},
	'{1'b0, 31, 1'b0, 1'b0, 1'b0},
	'{1'b0, 32, 1'b0, 1'b0, 1'b1},
	'{1'b0, 40, 1'b0, 1'b0, 1'b1},
	'{1'b0, 0, 1'b1, 1'b0, 1'b1},
	'{1'b0, 31, 1'b0, 1'b0, 1'b0},
	'{1'b0, 33, 1'b0, 1'b1, 1'b1},
	'{1'b0, 0, 1'b1, 1'b1, 1'b1},
	'{1'b0, 32, 1'b0, 1'b1, 1'b1},
	'{1'b1, 32, 1'b0, 1'b1, 1'b1},
	'{1'b0, 31, 1'b0, 1'b0, 1'b0},
	'{1'b0, 0, 1'b1, 1'b0, 1'b1},
	'{1'b0, 35, 1'b0, 1'b0, 1'b1},
	'{1'b0, 1, 1'b0, 1'b0, 1'b0}
};

// one shift of the reference LFSR
// the inverted XOR of taps 63, 62, 60 and 59 enters at bit 0
function automatic rng_pkg::lfsr_state_t lfsr_next(rng_pkg::lfsr_state_t s);
	logic fb;
	fb = ~(s[63] ^ s[62] ^ s[60] ^ s[59]);
	return {s[`RNG_LFSR_W-2:0], fb};
endfunction

// word results are compared as four-state values so X also fails
task automatic check_word(string name, rng_pkg::rng_word_t exp, rng_pkg::rng_word_t act);
	if (act !== exp) begin
		word_errors++;
		$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
	end
endtask

// single bit results such as fresh
task automatic check_flag(string name, logic exp, logic act);
	if (act !== exp) begin
		flag_errors++;
		$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
	end
endtask

// failures that have no single expected value
task automatic note_failure(string what);
	other_errors++;
	$display("error at %0t: %s", $time, what);
endtask

`endif

// ==== tb/tb_rng.sv ====
// testbench for the random word generator
// applies the stimulus table to the DUT and checks every read against
// a model of the fast LFSR, the slow contribution and the fresh rule

`timescale 1ns/1ps

`include "rng_macros.svh"

module tb_rng;

	logic               clk1;
	logic               clk2;
	logic               rst;
	logic               rd;
	rng_pkg::rng_word_t rng_word;
	logic               fresh;

	// clk2 toggles only while this bit is set and rests low otherwise
	logic clk2_run;

	int word_errors;
	int flag_errors;
	int other_errors;

	// clk1 edges since the last reset release
	// edge 1 is the first one with rst low
	int edge_cnt;

	// model copy of the fast LFSR and its low half after k shifts at index k
	rng_pkg::lfsr_state_t model_state;
	rng_pkg::rng_word_t   model_hist [$];

	// state carried from one row to the next
	logic               zero_expected;
	logic               slow_ref_valid;
	rng_pkg::rng_word_t slow_ref;
	rng_pkg::rng_word_t prev_off_word;
	int                 prev_off_m;
	logic               prev_on_valid;
	rng_pkg::rng_word_t prev_slow_on;

	`include "tb_rng_table.svh"

	rng_top i_rng_top (
		.clk1     (clk1),
		.clk2     (clk2),
		.rst      (rst),
		.rd       (rd),
		.rng_word (rng_word),
		.fresh    (fresh)
	);

	initial begin
		clk1 = 1'b0;
		forever #10 clk1 = ~clk1;
	end

	// the 7 ns offset keeps clk2 edges away from every clk1 edge
	initial begin
		clk2 = 1'b0;
		#7;
		forever begin
			#30;
			if (clk2_run) begin
				clk2 = ~clk2;
			end else begin
				clk2 = 1'b0;
			end
		end
	end

	// one clk1 edge after release, with the model stepped alongside
	task automatic tick();
		@(posedge clk1);
		edge_cnt++;
		model_state = lfsr_next(model_state);
		model_hist.push_back(model_state[`RNG_WORD_W-1:0]);
	endtask

	// rst high for 16 clk1 edges with clk2 running so the slow side sees it
	task automatic apply_reset();
		@(posedge clk1);
		rst <= 1'b1;
		rd <= 1'b0;
		clk2_run <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk1);
		end
		rst <= 1'b0;
		edge_cnt = 0;
		model_state = `RNG_SEED_FAST;
		model_hist.delete();
		model_hist.push_back(model_state[`RNG_WORD_W-1:0]);
	endtask

	// gap, read and checks for one table row
	task automatic run_row(int idx);
		row_t               row;
		int                 gap;
		int                 m;
		logic               exp_fresh;
		rng_pkg::rng_word_t got;
		rng_pkg::rng_word_t slow;
		row = table_rows[idx];
		if (row.rst_before) begin
			apply_reset();
			zero_expected = 1'b1;
			slow_ref_valid = 1'b0;
			prev_on_valid = 1'b0;
		end
		gap = row.rand_gap ? 32 + int'($urandom % 32) : row.gap;
		// fresh after k quiet edges follows the count
		// the level just before the read comes from the table
		for (int k = 1; k <= gap; k++) begin
			tick();
			clk2_run <= row.clk2_on;
			if (k == gap) begin
				rd <= 1'b1;
			end
			@(negedge clk1);
			exp_fresh = (k == gap) ? row.fresh_exp : (k >= `RNG_REFRESH_CYCLES);
			check_flag("fresh", exp_fresh, fresh);
			if (zero_expected) begin
				check_word("rng_word", '0, rng_word);
			end
		end
		// the read is sampled on this edge and fresh must drop with it
		tick();
		rd <= 1'b0;
		m = edge_cnt;
		@(negedge clk1);
		check_flag("fresh", 1'b0, fresh);
		got = rng_word;
		zero_expected = 1'b0;
		slow = got ^ model_hist[m - 2];
		if (!row.clk2_on) begin
			if (slow_ref_valid) begin
				check_word("slow contribution", slow_ref, slow);
				check_word("read xor", model_hist[m - 2] ^ model_hist[prev_off_m - 2],
					got ^ prev_off_word);
			end else begin
				if (slow == '0) begin
					note_failure("slow contribution is zero with clk2 stopped");
				end
				slow_ref = slow;
				slow_ref_valid = 1'b1;
			end
			prev_off_word = got;
			prev_off_m = m;
			prev_on_valid = 1'b0;
		end else begin
			if (prev_on_valid && slow == prev_slow_on) begin
				note_failure($sformatf("slow contribution unchanged at edge %0d", m));
			end
			prev_slow_on = slow;
			prev_on_valid = 1'b1;
			slow_ref_valid = 1'b0;
		end
	endtask

	initial begin
		rst <= 1'b1;
		rd <= 1'b0;
		clk2_run <= 1'b1;
		word_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		zero_expected = 1'b1;
		slow_ref_valid = 1'b0;
		prev_on_valid = 1'b0;
		void'($urandom(32'he733));
		for (int i = 0; i < num_rows; i++) begin
			run_row(i);
		end
		$display("word errors %0d, flag errors %0d, other errors %0d",
			word_errors, flag_errors, other_errors);
		if (word_errors == 0 && flag_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
